//--- all.f
design/rv_pkg.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_decode.sv
design/rv_fetch.sv
design/rv_core.sv
verif/rv_core_checker.sv
verif/rv_core_tb.sv

//--- design/rv_alu.sv
`timescale 1ns/1ns

module rv_alu (
  input  rv_pkg::alu_op_e  op,
  input  rv_pkg::word_t    a,
  input  rv_pkg::word_t    b,
  input  rv_pkg::br_cond_e br_cond,
  output rv_pkg::word_t    result,
  output logic             br_true
);

  logic [4:0] shamt;
  logic       lt_s, lt_u;

  assign shamt = b[4:0];  // Upper bits ignored
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb begin
    case (op)
      rv_pkg::alu_add:    result = a + b;
      rv_pkg::alu_sub:    result = a - b;  // Wraps on overflow
      rv_pkg::alu_sll:    result = a << shamt;
      rv_pkg::alu_slt:    result = {31'b0, lt_s};
      rv_pkg::alu_sltu:   result = {31'b0, lt_u};
      rv_pkg::alu_xor:    result = a ^ b;
      rv_pkg::alu_srl:    result = a >> shamt;
      rv_pkg::alu_sra:    result = $signed(a) >>> shamt;
      rv_pkg::alu_or:     result = a | b;
      rv_pkg::alu_and:    result = a & b;
      rv_pkg::alu_pass_b: result = b;
      default:            result = '0;
    endcase
  end

  // Branch compare on the two register operands
  always_comb begin
    case (br_cond)
      rv_pkg::br_eq:  br_true = (a == b);
      rv_pkg::br_ne:  br_true = (a != b);
      rv_pkg::br_lt:  br_true = lt_s;
      rv_pkg::br_ge:  br_true = !lt_s;
      rv_pkg::br_ltu: br_true = lt_u;
      rv_pkg::br_geu: br_true = !lt_u;
      default:        br_true = 1'b0;  // Reserved encodings
    endcase
  end

endmodule

//--- design/rv_core.sv
`timescale 1ns/1ns

module rv_core (
  input  logic            clk,
  input  logic            rst,
  output rv_pkg::word_t   pc,
  input  rv_pkg::fetch_t  fetch,
  output logic            insn_ready,
  output rv_pkg::retire_t retire,
  output logic            retire_valid,
  output logic            halt
);

  logic             accept;
  rv_pkg::insn_t    insn;
  rv_pkg::alu_op_e  alu_op;
  rv_pkg::br_cond_e br_cond;
  rv_pkg::word_t    imm, b_imm, alu_b, alu_result;
  rv_pkg::word_t    rs1_data, rs2_data;
  logic             use_imm, is_branch, writes_rd, is_ecall, illegal;
  logic             br_true, wr_en, taken, halt_req;
  rv_pkg::retire_t  retire_d;

  assign accept = fetch.valid & insn_ready;
  assign insn   = fetch.insn;

  rv_fetch u_fetch (
    .clk(clk), .rst(rst), .accept(accept), .taken(taken), .halt_req(halt_req),
    .b_imm(b_imm), .pc(pc), .halt(halt), .insn_ready(insn_ready)
  );

  rv_decode u_decode (
    .insn(insn), .alu_op(alu_op), .use_imm(use_imm), .imm(imm), .b_imm(b_imm),
    .br_cond(br_cond), .is_branch(is_branch), .writes_rd(writes_rd),
    .is_ecall(is_ecall), .illegal(illegal)
  );

  rv_regfile u_regfile (
    .clk(clk), .rst(rst), .rs1(insn.r_fmt.rs1), .rs2(insn.r_fmt.rs2),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .rd(insn.r_fmt.rd),
    .wdata(alu_result), .we(wr_en & accept)
  );

  assign alu_b = use_imm ? imm : rs2_data;

  rv_alu u_alu (
    .op(alu_op), .a(rs1_data), .b(alu_b), .br_cond(br_cond),
    .result(alu_result), .br_true(br_true)
  );

  assign wr_en    = writes_rd && insn.r_fmt.rd != '0;  // x0 target counts as no write
  assign taken    = accept & is_branch & br_true;
  assign halt_req = accept & is_ecall;

  // Record of the instruction accepted this cycle
  always_comb begin
    retire_d.pc      = pc;
    retire_d.rd      = wr_en ? insn.r_fmt.rd : '0;
    retire_d.wdata   = wr_en ? alu_result : '0;
    retire_d.we      = wr_en;
    retire_d.illegal = illegal;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      retire_valid <= 1'b0;
    else
      retire_valid <= accept;  // One pulse per acceptance
  end

  always_ff @(posedge clk) begin
    if (accept)
      retire <= retire_d;
  end

endmodule

//--- design/rv_decode.sv
`timescale 1ns/1ns

module rv_decode (
  input  rv_pkg::insn_t    insn,
  output rv_pkg::alu_op_e  alu_op,
  output logic             use_imm,
  output rv_pkg::word_t    imm,
  output rv_pkg::word_t    b_imm,
  output rv_pkg::br_cond_e br_cond,
  output logic             is_branch,
  output logic             writes_rd,
  output logic             is_ecall,
  output logic             illegal
);

  // Shared funct3 map for register-immediate and register-register
  function automatic rv_pkg::alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
    rv_pkg::alu_op_e op;
    case (f3)
      rv_pkg::f3_add_sub: op = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
      rv_pkg::f3_sll:     op = rv_pkg::alu_sll;
      rv_pkg::f3_slt:     op = rv_pkg::alu_slt;
      rv_pkg::f3_sltu:    op = rv_pkg::alu_sltu;
      rv_pkg::f3_xor:     op = rv_pkg::alu_xor;
      rv_pkg::f3_srl_sra: op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      rv_pkg::f3_or:      op = rv_pkg::alu_or;
      rv_pkg::f3_and:     op = rv_pkg::alu_and;
      default:            op = rv_pkg::alu_add;
    endcase
    return op;
  endfunction

  logic [6:0]    funct7;
  logic [2:0]    funct3;
  logic          f7_base, f7_alt;
  logic          ecall_zero;  // All fields above the opcode clear
  logic          branch_raw, writes_raw;
  rv_pkg::word_t i_imm, u_imm;

  assign funct7  = insn.r_fmt.funct7;
  assign funct3  = insn.r_fmt.funct3;
  assign f7_base = (funct7 == rv_pkg::funct7_base);
  assign f7_alt  = (funct7 == rv_pkg::funct7_alt);

  assign ecall_zero = ({funct7, insn.r_fmt.rs2, insn.r_fmt.rs1, funct3, insn.r_fmt.rd} == '0);

  assign i_imm = {{20{funct7[6]}}, funct7, insn.r_fmt.rs2};
  assign u_imm = {funct7, insn.r_fmt.rs2, insn.r_fmt.rs1, funct3, 12'b0};
  assign b_imm = {{20{insn.b_fmt.imm12}}, insn.b_fmt.imm11, insn.b_fmt.imm10_5,
                  insn.b_fmt.imm4_1, 1'b0};

  always_comb begin
    alu_op     = rv_pkg::alu_add;
    use_imm    = 1'b0;
    imm        = i_imm;
    br_cond    = rv_pkg::br_cond_e'(insn.b_fmt.funct3);
    branch_raw = 1'b0;
    writes_raw = 1'b0;
    is_ecall   = 1'b0;
    illegal    = 1'b0;
    case (insn.r_fmt.opcode)
      rv_pkg::op_lui: begin
        alu_op     = rv_pkg::alu_pass_b;
        use_imm    = 1'b1;
        imm        = u_imm;
        writes_raw = 1'b1;
      end
      rv_pkg::op_reg_imm: begin
        // funct7 is plain immediate except on shifts
        alu_op     = alu_from_f3(funct3, f7_alt && funct3 == rv_pkg::f3_srl_sra);
        use_imm    = 1'b1;
        writes_raw = 1'b1;
        if (funct3 == rv_pkg::f3_sll)
          illegal = !f7_base;
        else if (funct3 == rv_pkg::f3_srl_sra)
          illegal = !(f7_base || f7_alt);
      end
      rv_pkg::op_reg_reg: begin
        alu_op     = alu_from_f3(funct3, f7_alt);
        writes_raw = 1'b1;
        illegal    = !(f7_base || (f7_alt && (funct3 == rv_pkg::f3_add_sub ||
                                              funct3 == rv_pkg::f3_srl_sra)));
      end
      rv_pkg::op_branch: begin
        branch_raw = 1'b1;
        illegal    = (funct3[2:1] == 2'b01);  // No branch at 010 or 011
      end
      rv_pkg::op_environ: begin
        is_ecall = ecall_zero;
        illegal  = !ecall_zero;
      end
      default: illegal = 1'b1;
    endcase
  end

  // Illegal words neither write nor redirect
  assign writes_rd = writes_raw & ~illegal;
  assign is_branch = branch_raw & ~illegal;

endmodule

//--- design/rv_fetch.sv
`timescale 1ns/1ns

module rv_fetch (
  input  logic          clk,
  input  logic          rst,
  input  logic          accept,
  input  logic          taken,
  input  logic          halt_req,
  input  rv_pkg::word_t b_imm,
  output rv_pkg::word_t pc,
  output logic          halt,
  output logic          insn_ready
);

  rv_pkg::word_t pc_q;
  logic          halted;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc_q   <= '0;
      halted <= 1'b0;
    end else if (accept) begin
      pc_q <= taken ? pc_q + b_imm : pc_q + 32'd4;
      if (halt_req)
        halted <= 1'b1;  // Sticky until reset
    end
  end

  assign pc         = pc_q;
  assign halt       = halted;
  assign insn_ready = ~halted;  // No more fetches once halted

endmodule

//--- design/rv_pkg.sv
package rv_pkg;

  localparam int xlen      = 32;  // Register and PC width
  localparam int reg_count = 32;

  typedef logic [4:0]      reg_idx_t;
  typedef logic [xlen-1:0] word_t;

  // Major opcodes handled by the core
  localparam logic [6:0] op_lui     = 7'b0110111;
  localparam logic [6:0] op_reg_imm = 7'b0010011;
  localparam logic [6:0] op_reg_reg = 7'b0110011;
  localparam logic [6:0] op_branch  = 7'b1100011;
  localparam logic [6:0] op_environ = 7'b1110011;

  // The only two legal funct7 values
  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000;  // SUB, SRA, SRAI

  // funct3 of the integer group
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b  // LUI result is the immediate itself
  } alu_op_e;

  // Values match the branch funct3
  typedef enum logic [2:0] {
    br_eq  = 3'b000,
    br_ne  = 3'b001,
    br_lt  = 3'b100,
    br_ge  = 3'b101,
    br_ltu = 3'b110,
    br_geu = 3'b111
  } br_cond_e;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // Branch layout with the scattered offset bits
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    b_fmt_t b_fmt;
  } insn_t;

  typedef struct packed {
    word_t    pc;
    reg_idx_t rd;
    word_t    wdata;
    logic     we;
    logic     illegal;
  } retire_t;

  typedef struct packed {
    insn_t insn;
    logic  valid;
  } fetch_t;

endpackage

//--- design/rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t    wdata,
  input  logic             we
);

  rv_pkg::word_t regs [rv_pkg::reg_count];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < rv_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin  // x0 never written
      regs[rd] <= wdata;
    end
  end

  // Read ports
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- verif/rv_core_checker.sv
`timescale 1ns/1ns

module rv_core_checker (
  input logic           clk,
  input logic           rst,
  input rv_pkg::fetch_t fetch,
  input rv_pkg::word_t  pc,
  input logic           insn_ready,
  input logic           retire_valid,
  input logic           halt
);

  logic accept;
  int   fail_count;

  assign accept = fetch.valid & insn_ready;

  retire_after_accept: assert property (@(posedge clk) disable iff (rst)
    retire_valid |-> $past(accept))
    else begin
      $error("retire_valid without an acceptance");
      fail_count++;
    end

  // Stall keeps the PC
  pc_holds_on_stall: assert property (@(posedge clk) disable iff (rst)
    !fetch.valid |=> $stable(pc))
    else begin
      $error("pc moved while fetch.valid was low");
      fail_count++;
    end

  halt_sticky: assert property (@(posedge clk) disable iff (rst)
    halt |=> halt)
    else begin
      $error("halt fell outside reset");
      fail_count++;
    end

  ready_low_in_halt: assert property (@(posedge clk) disable iff (rst)
    halt |-> !insn_ready)
    else begin
      $error("insn_ready high while halted");
      fail_count++;
    end

endmodule

bind rv_core rv_core_checker u_checker (
  .clk(clk), .rst(rst), .fetch(fetch), .pc(pc), .insn_ready(insn_ready),
  .retire_valid(retire_valid), .halt(halt)
);

//--- verif/rv_core_stim.txt
// Line 1: program word count, retire record count; then program words by address
// Records after that: pc rd wdata we illegal
0000002c 00000026
800000b7 ffb00113 fff08193 ffc12213
00713293 0f014313 55026393 7f037413
00439493 0030d513 4030d593 00418633
404086b3 00921733 003127b3 0011b833
002348b3 00415933 404159b3 01146a33
0144fab3 12338013 00700b33 00438463
01638463 00100f93 01639463 00439463
00100f93 0021c463 00314463 00100f93
00315463 0021d463 00100f93 00316463
0021e463 00100f93 0021f463 00317463
00100f93 02420bb3 004b8c33 00000073
00000000 01 80000000 1 0   00000004 02 fffffffb 1 0   00000008 03 7fffffff 1 0
0000000c 04 00000001 1 0   00000010 05 00000000 1 0   00000014 06 ffffff0b 1 0
00000018 07 00000551 1 0   0000001c 08 00000700 1 0   00000020 09 00005510 1 0
00000024 0a 10000000 1 0   00000028 0b f0000000 1 0   0000002c 0c 80000000 1 0
00000030 0d 7fffffff 1 0   00000034 0e 00010000 1 0   00000038 0f 00000001 1 0
0000003c 10 00000001 1 0   00000040 11 000000f0 1 0   00000044 12 7ffffffd 1 0
00000048 13 fffffffd 1 0   0000004c 14 000007f0 1 0   00000050 15 00000510 1 0
00000054 00 00000000 0 0   00000058 16 00000551 1 0   0000005c 00 00000000 0 0
00000060 00 00000000 0 0   00000068 00 00000000 0 0   0000006c 00 00000000 0 0
00000074 00 00000000 0 0   00000078 00 00000000 0 0   00000080 00 00000000 0 0
00000084 00 00000000 0 0   0000008c 00 00000000 0 0   00000090 00 00000000 0 0
00000098 00 00000000 0 0   0000009c 00 00000000 0 0   000000a4 00 00000000 0 1
000000a8 18 00000001 1 0   000000ac 00 00000000 0 0

//--- verif/rv_core_tb.sv
`timescale 1ns/1ns

module rv_core_tb;

  localparam int stim_words = 256;
  localparam int mem_words  = 128;

  logic            clk;
  logic            rst;
  rv_pkg::fetch_t  fetch;
  rv_pkg::word_t   pc;
  logic            insn_ready;
  rv_pkg::retire_t retire;
  logic            retire_valid;
  logic            halt;

  logic [31:0]     stim [stim_words];
  rv_pkg::word_t   imem [mem_words];
  rv_pkg::retire_t expected [$];
  int              prog_len;
  int              rec_count;
  int              cycles;
  int              limit;
  integer          seed;

  rv_core uut (
    .clk(clk), .rst(rst), .pc(pc), .fetch(fetch), .insn_ready(insn_ready),
    .retire(retire), .retire_valid(retire_valid), .halt(halt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic fail_run();
    $display("Test failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_field(input string name, input rv_pkg::word_t got,
                             input rv_pkg::word_t exp);
    assert (got == exp) else begin
      $display("Error: %s = %h, expected %h", name, got, exp);
      fail_run();
    end
  endtask

  // Bound handshake and halt rules
  task automatic check_bound_asserts();
    assert (uut.u_checker.fail_count == 0) else begin
      $display("A bound assertion on the core failed");
      fail_run();
    end
  endtask

  // Program image first, then five words per expected record
  task automatic load_stim();
    int              base;
    rv_pkg::retire_t rec;
    $readmemh("verif/rv_core_stim.txt", stim);
    prog_len  = stim[0];
    rec_count = stim[1];
    assert (prog_len > 0 && prog_len <= mem_words) else begin
      $display("Stim file gives an unusable program length of %0d words", prog_len);
      fail_run();
    end
    for (int i = 0; i < prog_len; i++) begin
      imem[i] = stim[2 + i];
    end
    base = 2 + prog_len;
    for (int r = 0; r < rec_count; r++) begin
      rec.pc      = stim[base + 5 * r];
      rec.rd      = stim[base + 5 * r + 1][4:0];
      rec.wdata   = stim[base + 5 * r + 2];
      rec.we      = stim[base + 5 * r + 3][0];
      rec.illegal = stim[base + 5 * r + 4][0];
      expected.push_back(rec);
    end
    limit = 8 * prog_len + 50;
  endtask

  // Memory model, words past the program decode as illegal
  function automatic rv_pkg::word_t word_at(input rv_pkg::word_t addr);
    if (addr[31:2] < prog_len)
      return imem[addr[31:2]];
    return {addr[31:7] ^ addr[24:0], 7'h7f};
  endfunction

  task automatic drive_fetch();
    fetch.valid = ($random(seed) & 3) != 0;  // Gap about one cycle in four
    fetch.insn  = word_at(pc);
  endtask

  task automatic check_retire();
    rv_pkg::retire_t exp;
    assert (expected.size() > 0) else begin
      $display("Retire record at pc %h arrived after the last expected one", retire.pc);
      fail_run();
    end
    exp = expected.pop_front();
    check_field("retire.pc", retire.pc, exp.pc);
    check_field("retire.rd", retire.rd, exp.rd);
    check_field("retire.wdata", retire.wdata, exp.wdata);
    check_field("retire.we", retire.we, exp.we);
    check_field("retire.illegal", retire.illegal, exp.illegal);
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      cycles++;
      check_bound_asserts();
      if (retire_valid)
        check_retire();
      if (cycles >= limit) begin
        $display("Timeout: the core did not halt within %0d cycles", limit);
        fail_run();
      end
    end
  end

  initial begin
    seed   = 25665;
    cycles = 0;
    rst    = 1'b1;
    fetch  = '0;
    load_stim();
    repeat (8) @(posedge clk);
    #2 rst = 1'b0;
    check_field("pc", pc, 32'h0);
    check_field("insn_ready", insn_ready, 32'h1);
    check_field("retire_valid", retire_valid, 32'h0);
    check_field("halt", halt, 32'h0);
    drive_fetch();
    while (!halt) begin
      @(posedge clk);
      #2;
      drive_fetch();
    end
    check_field("insn_ready", insn_ready, 32'h0);
    repeat (4) @(negedge clk);  // Any late record fails in the monitor
    check_bound_asserts();
    if (expected.size() == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("Core halted with %0d expected records never retired", expected.size());
      fail_run();
    end
  end

endmodule
